// ==== src/sine_quarter.svh ====
// quarter wave of sin, entry k = round(2047 * sin(2*pi*k/256))
// the last entry is the peak, so 65 entries cover 0..pi/2 inclusive

localparam logic [SAMPLE_W-2:0] SINE_Q [0:64] = '{
   0,    50,   100,  151,  201,  251,  300,  350,    // 0..7
   399,  449,  497,  546,  594,  642,  690,  737,    // 8..15
   783,  830,  875,  920,  965,  1009, 1052, 1095,   // 16..23
   1137, 1179, 1219, 1259, 1299, 1337, 1375, 1411,   // 24..31
   1447, 1483, 1517, 1550, 1582, 1614, 1644, 1674,   // 32..39
   1702, 1729, 1756, 1781, 1805, 1828, 1850, 1871,   // 40..47
   1891, 1910, 1927, 1944, 1959, 1973, 1986, 1997,   // 48..55
   2008, 2017, 2025, 2032, 2037, 2041, 2045, 2046,   // 56..63
   2047                                              // peak
};

// full-turn sine from the quarter table
// quadrant in the top two index bits, offset j in the rest
function automatic sample_t sine_lookup(input logic [IDX_W-1:0] idx);
   logic [1:0]         quad;
   logic [IDX_W-3:0]   j;
   logic [IDX_W-2:0]   k;
   sample_t            mag;
   quad = idx[IDX_W-1 -: 2];
   j    = idx[IDX_W-3:0];

   // odd quadrants run the table backwards
   if (quad[0])
   begin
      k = (IDX_W-1)'(1 << (IDX_W-2)) - {1'b0, j};
   end
   else
   begin
      k = {1'b0, j};
   end

   mag = $signed({1'b0, SINE_Q[k]});

   // lower half of the turn is negative
   if (quad[1])
   begin
      return -mag;
   end
   return mag;
endfunction

// ==== src/dds_pkg.sv ====
package dds_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////
   localparam int PHASE_W  = 32;   // phase accumulator
   localparam int IDX_W    = 8;    // table index, top bits of phase
   localparam int SAMPLE_W = 12;   // signed sample

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // full scale, symmetric about zero
   localparam sample_t AMP_MAX = 2047;
   localparam sample_t AMP_MIN = -2047;

   ////////////////////////////////////////////////////////////
   // selector encodings
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      WAVE_SINE   = 2'd0,
      WAVE_COS    = 2'd1,
      WAVE_SAW    = 2'd2,
      WAVE_SQUARE = 2'd3
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK  = 2'd0,
      MOD_FSK  = 2'd1,
      MOD_BPSK = 2'd2,
      MOD_LFSR = 2'd3
   } mod_sel_e;

   ////////////////////////////////////////////////////////////
   // payloads
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      wave_sel_e          wave_sel;
      mod_sel_e           mod_sel;
      logic [PHASE_W-1:0] fsk_inc;   // increment while lfsr bit is 1
   } dds_cfg_t;

   typedef struct packed {
      wave_sel_e        wave_sel;
      logic [IDX_W-1:0] phase_idx;
      sample_t          sample;
   } wave_sample_t;

   typedef struct packed {
      mod_sel_e         mod_sel;
      logic [IDX_W-1:0] phase_idx;
      logic             lfsr_bit;   // data bit the sample was formed with
      sample_t          sample;
   } mod_sample_t;

endpackage

// ==== src/mod_control.sv ====
`timescale 1ns/1ps

module mod_control import dds_pkg::*;
#(
   parameter int unsigned BASE_INC   = 258,
   parameter int unsigned LFSR_DIV   = 50,
   parameter int unsigned SAMPLE_DIV = 7
)
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_cfg_t           cfg,
   input  logic               cfg_valid,
   input  logic               lfsr_bit,
   output logic [PHASE_W-1:0] phase_inc,
   output logic               lfsr_step,
   output logic               sample_tick,
   output wave_sel_e          wave_sel,
   output mod_sel_e           mod_sel
);

   // both dividers share one counter width, sized for the longer one
   localparam int unsigned DIV_MAX = (LFSR_DIV > SAMPLE_DIV) ? LFSR_DIV : SAMPLE_DIV;
   localparam int          CNT_W   = $clog2(DIV_MAX + 1);
   localparam int unsigned DIVS [2] = '{LFSR_DIV, SAMPLE_DIV};

   dds_cfg_t         cfg_q;
   logic [CNT_W-1:0] div_cnt [2];
   logic [1:0]       tick;            // 0 lfsr, 1 sample

   ////////////////////////////////////////////////////////////
   // configuration register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         cfg_q <= '{wave_sel: WAVE_SINE, mod_sel: MOD_ASK, fsk_inc: '0};
      end
      else if (cfg_valid)
      begin
         cfg_q <= cfg;                 // takes effect next cycle
      end
   end

   assign wave_sel = cfg_q.wave_sel;
   assign mod_sel  = cfg_q.mod_sel;

   ////////////////////////////////////////////////////////////
   // tick dividers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (reset_from_key)
         begin
            div_cnt[i] <= '0;
            tick[i]    <= 1'b0;
         end
         else if (div_cnt[i] == CNT_W'(DIVS[i] - 1))
         begin
            div_cnt[i] <= '0;
            tick[i]    <= 1'b1;        // one cycle wide
         end
         else
         begin
            div_cnt[i] <= div_cnt[i] + 1'b1;
            tick[i]    <= 1'b0;
         end
      end
   end

   assign lfsr_step   = tick[0];
   assign sample_tick = tick[1];

   // fsk hops to the configured word while the data bit is 1
   assign phase_inc = (cfg_q.mod_sel == MOD_FSK && lfsr_bit) ? cfg_q.fsk_inc
                                                             : PHASE_W'(BASE_INC);

   // output buffers expect at most one load per sample interval
   a_tick_gap: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (SAMPLE_DIV > 1 && sample_tick) |=> !sample_tick);

endmodule

// ==== src/dds_core.sv ====
`timescale 1ns/1ps

module dds_core import dds_pkg::*;
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  logic [PHASE_W-1:0] phase_inc,
   output logic [IDX_W-1:0]   phase_idx,
   output sample_t            sin_out,
   output sample_t            cos_out,
   output sample_t            saw_out,
   output sample_t            squ_out
);

`include "sine_quarter.svh"

   localparam logic [IDX_W-1:0] QUARTER_TURN = IDX_W'(1 << (IDX_W-2));

   logic [PHASE_W-1:0] phase_acc;
   logic [IDX_W-1:0]   acc_idx;

   assign acc_idx = phase_acc[PHASE_W-1 -: IDX_W];   // coarse phase for the table

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_acc <= '0;
      end
      else
      begin
         phase_acc <= phase_acc + phase_inc;   // wraps at full turn
      end
   end

   ////////////////////////////////////////////////////////////
   // waveform stage
   ////////////////////////////////////////////////////////////
   // index travels with the samples built from it
   always_ff @(posedge CLK_25MHZ)
   begin
      phase_idx <= acc_idx;
      sin_out   <= sine_lookup(acc_idx);
      cos_out   <= sine_lookup(acc_idx + QUARTER_TURN);       // quarter turn ahead
      saw_out   <= $signed({acc_idx, {(SAMPLE_W-IDX_W){1'b0}}});
      squ_out   <= acc_idx[IDX_W-1] ? AMP_MIN : AMP_MAX;     // sign of sine
   end

endmodule

// ==== src/lfsr_source.sv ====
`timescale 1ns/1ps

module lfsr_source
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   input  logic lfsr_step,
   output logic lfsr_bit
);

   logic [4:0] lfsr;

   // x^5 + x^3 + 1, maximal length 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= 5'b00001;
      end
      else if (lfsr_step)
      begin
         lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[2]};   // shift up, feed bit 0
      end
   end

   assign lfsr_bit = lfsr[0];

   // zero state would lock the sequence for good
   a_no_lockup: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != 5'b00000);

endmodule

// ==== src/modulator.sv ====
`timescale 1ns/1ps

module modulator import dds_pkg::*;
(
   input  logic             CLK_25MHZ,
   input  logic             reset_from_key,
   input  logic [IDX_W-1:0] phase_idx,
   input  sample_t          sin_out,
   input  sample_t          cos_out,
   input  sample_t          saw_out,
   input  sample_t          squ_out,
   input  wave_sel_e        wave_sel,
   input  mod_sel_e         mod_sel,
   input  logic             lfsr_bit,
   output wave_sample_t     wave_res,
   output mod_sample_t      mod_res
);

   wave_sample_t wave_nxt;
   mod_sample_t  mod_nxt;

   always_comb
   begin
      wave_nxt.wave_sel  = wave_sel;
      wave_nxt.phase_idx = phase_idx;
      case (wave_sel)
         WAVE_SINE:   wave_nxt.sample = sin_out;
         WAVE_COS:    wave_nxt.sample = cos_out;
         WAVE_SAW:    wave_nxt.sample = saw_out;
         WAVE_SQUARE: wave_nxt.sample = squ_out;
      endcase

      // every modulation rides on the cosine carrier
      mod_nxt.mod_sel   = mod_sel;
      mod_nxt.phase_idx = phase_idx;
      mod_nxt.lfsr_bit  = lfsr_bit;
      case (mod_sel)
         MOD_ASK:  mod_nxt.sample = lfsr_bit ? cos_out : sample_t'(0);   // on/off keying
         MOD_FSK:  mod_nxt.sample = cos_out;            // hop is in the increment
         MOD_BPSK: mod_nxt.sample = lfsr_bit ? cos_out : -cos_out;
         MOD_LFSR: mod_nxt.sample = lfsr_bit ? sample_t'(0) : AMP_MIN;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_res <= '0;
         mod_res  <= '0;
      end
      else
      begin
         wave_res <= wave_nxt;
         mod_res  <= mod_nxt;
      end
   end

endmodule

// ==== src/sample_outbuf.sv ====
`timescale 1ns/1ps

module sample_outbuf
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic        CLK_25MHZ,
   input  logic        reset_from_key,
   input  logic        sample_tick,
   input  payload_t    in_data,
   input  logic        ready,
   output payload_t    out_data,
   output logic        valid,
   output logic [15:0] drop_count
);

   logic blocked;

   assign blocked = valid && !ready;   // item held and not taken this cycle

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         valid      <= 1'b0;
         drop_count <= '0;
      end
      else if (sample_tick)
      begin
         if (blocked)
         begin
            drop_count <= drop_count + 16'd1;   // consumer too slow, tick lost
         end
         else
         begin
            valid <= 1'b1;
         end
      end
      else if (valid && ready)
      begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (sample_tick && !blocked)
      begin
         out_data <= in_data;
      end
   end

   // a stalled item stays put until the consumer takes it
   a_hold_stable: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      blocked |=> valid && $stable(out_data));

endmodule

// ==== src/dds_mod_top.sv ====
`timescale 1ns/1ps

module dds_mod_top import dds_pkg::*;
#(
   parameter int unsigned BASE_INC   = 258,
   parameter int unsigned LFSR_DIV   = 50,
   parameter int unsigned SAMPLE_DIV = 7
)
(
   input  logic         CLK_25MHZ,
   input  logic         reset_from_key,
   input  dds_cfg_t     cfg,
   input  logic         cfg_valid,
   input  logic         wave_ready,
   input  logic         mod_ready,
   output wave_sample_t wave_data,
   output logic         wave_valid,
   output mod_sample_t  mod_data,
   output logic         mod_valid,
   output logic [15:0]  wave_drops,
   output logic [15:0]  mod_drops
);

   logic [PHASE_W-1:0] phase_inc;
   logic               lfsr_step;
   logic               sample_tick;
   logic               lfsr_bit;
   wave_sel_e          wave_sel;
   mod_sel_e           mod_sel;
   logic [IDX_W-1:0]   phase_idx;
   sample_t            sin_out;
   sample_t            cos_out;
   sample_t            saw_out;
   sample_t            squ_out;
   wave_sample_t       wave_res;
   mod_sample_t        mod_res;

   ////////////////////////////////////////////////////////////
   // control and data bit
   ////////////////////////////////////////////////////////////
   mod_control #(
      .BASE_INC   (BASE_INC),
      .LFSR_DIV   (LFSR_DIV),
      .SAMPLE_DIV (SAMPLE_DIV)
   ) mod_control_i (.*);

   lfsr_source lfsr_source_i (.*);

   ////////////////////////////////////////////////////////////
   // datapath, two register stages
   ////////////////////////////////////////////////////////////
   dds_core dds_core_i (.*);

   modulator modulator_i (.*);

   ////////////////////////////////////////////////////////////
   // output streams to the slow consumer
   ////////////////////////////////////////////////////////////
   sample_outbuf #(.payload_t(wave_sample_t)) wave_outbuf (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_tick    (sample_tick),
      .in_data        (wave_res),
      .ready          (wave_ready),
      .out_data       (wave_data),
      .valid          (wave_valid),
      .drop_count     (wave_drops)
   );

   sample_outbuf #(.payload_t(mod_sample_t)) mod_outbuf (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_tick    (sample_tick),
      .in_data        (mod_res),
      .ready          (mod_ready),
      .out_data       (mod_data),
      .valid          (mod_valid),
      .drop_count     (mod_drops)
   );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
#(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
)
(
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   initial
   begin
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;   // released on a rising edge
   end

   always #(PERIOD_NS / 2) CLK_25MHZ = ~CLK_25MHZ;

endmodule

// ==== tb/dds_mod_checker.sv ====
`timescale 1ns/1ps

module dds_mod_checker import dds_pkg::*;
#(
   parameter int unsigned BASE_INC   = 258,
   parameter int unsigned LFSR_DIV   = 50,
   parameter int unsigned SAMPLE_DIV = 7
)
(
   input  logic         CLK_25MHZ,
   input  logic         reset_from_key,
   input  dds_cfg_t     cfg,
   input  logic         cfg_valid,
   input  logic         wave_ready,
   input  logic         mod_ready,
   input  wave_sample_t wave_data,
   input  logic         wave_valid,
   input  mod_sample_t  mod_data,
   input  logic         mod_valid,
   input  logic [15:0]  wave_drops,
   input  logic [15:0]  mod_drops,
   output int           mismatch_count,
   output int           fault_count,
   output int           accept_count
);

`include "sine_quarter.svh"

   int           cyc;             // rising edges since reset ended
   int           exp_drops [2];   // 0 wave, 1 mod
   logic [1:0]   exp_vld;         // valid due this cycle
   logic [1:0]   prev_blk;
   wave_sample_t prev_wave;
   mod_sample_t  prev_mod;
   dds_cfg_t     cfg_m;
   logic [4:0]   lfsr_m;
   logic         seq [512];       // data bits in step order
   int           lfsr_pos;
   int           last_pos;
   int           load_k;
   int           prev_k;
   logic [7:0]   prev_idx;
   logic         have_prev;
   logic         hop_flag;        // fsk hopping seen since the last load
   logic         hop_win;
   logic         item_hop;
   logic         rst_seen;

   initial
   begin
      mismatch_count = 0;
      fault_count    = 0;
      accept_count   = 0;
      rst_seen       = 1'b0;
   end

   task automatic flag_mismatch(input string msg);
      mismatch_count++;
      $display("Mismatch at time %0t: %s", $time, msg);
   endtask

   task automatic flag_fault(input string msg);
      fault_count++;
      $display("Error at time %0t: %s", $time, msg);
   endtask

   ////////////////////////////////////////////////////////////
   // reference waveforms
   ////////////////////////////////////////////////////////////
   function automatic int sine_ref(input int idx);
      int quad;
      int mag;
      quad = idx / 64 % 4;
      mag  = (quad % 2 == 1) ? int'(SINE_Q[64 - idx % 64]) : int'(SINE_Q[idx % 64]);
      return (quad >= 2) ? -mag : mag;
   endfunction

   function automatic int wave_ref(input wave_sel_e sel, input int idx);
      case (sel)
         WAVE_SINE: return sine_ref(idx);
         WAVE_COS:  return sine_ref((idx + 64) % 256);
         WAVE_SAW:  return (idx < 128) ? idx * 16 : idx * 16 - 4096;
         default:   return (idx < 128) ? 2047 : -2047;
      endcase
   endfunction

   function automatic int mod_ref(input mod_sel_e sel, input int idx, input logic b);
      int c;
      c = sine_ref((idx + 64) % 256);   // carrier
      case (sel)
         MOD_ASK:  return b ? c : 0;
         MOD_FSK:  return c;
         MOD_BPSK: return b ? c : -c;
         default:  return b ? 0 : -2047;
      endcase
   endfunction

   task automatic check_wave(input wave_sample_t w);
      int exp;
      accept_count++;
      exp = wave_ref(w.wave_sel, w.phase_idx);
      if (int'(w.sample) != exp)
         flag_mismatch($sformatf("wave sel %0d idx %0d gave %0d, expected %0d",
                                 w.wave_sel, w.phase_idx, w.sample, exp));
   endtask

   task automatic check_mod(input mod_sample_t m);
      int                 exp;
      int                 p;
      logic [PHASE_W-1:0] d;
      logic [IDX_W-1:0]   step;
      accept_count++;
      exp = mod_ref(m.mod_sel, m.phase_idx, m.lfsr_bit);
      if (int'(m.sample) != exp)
         flag_mismatch($sformatf("mod sel %0d idx %0d bit %0d gave %0d, expected %0d",
                                 m.mod_sel, m.phase_idx, m.lfsr_bit, m.sample, exp));
      p = last_pos;
      while (p <= lfsr_pos && seq[p] != m.lfsr_bit)
         p++;
      if (p > lfsr_pos)
         flag_mismatch($sformatf("lfsr bit %0d not found from step %0d", m.lfsr_bit, last_pos));
      else
         last_pos = p;
      // idx step must match whole sample intervals unless fsk hopped
      if (have_prev && !item_hop)
      begin
         d    = PHASE_W'(load_k - prev_k) * PHASE_W'(BASE_INC);
         step = m.phase_idx - prev_idx;
         if (step != d[PHASE_W-1 -: IDX_W] && step != d[PHASE_W-1 -: IDX_W] + 8'd1)
            flag_mismatch($sformatf("idx moved by %0d over %0d cycles", step, load_k - prev_k));
      end
      have_prev = 1'b1;
      prev_k    = load_k;
      prev_idx  = m.phase_idx;
   endtask

   ////////////////////////////////////////////////////////////
   // per-cycle monitor at the falling edge
   ////////////////////////////////////////////////////////////
   always @(negedge CLK_25MHZ)
   begin
      logic [1:0] vld;
      logic [1:0] blk;
      logic [1:0] changed;
      logic       tick;
      logic       hopping;
      vld     = {mod_valid, wave_valid};
      blk     = vld & ~{mod_ready, wave_ready};
      changed = {mod_data != prev_mod, wave_data != prev_wave};
      if (reset_from_key !== 1'b0)
      begin
         if (rst_seen && vld != 2'b00)
            flag_fault("valid is high during reset");
         rst_seen     = 1'b1;
         cyc          = 0;
         exp_drops[0] = 0;
         exp_drops[1] = 0;
         exp_vld      = 2'b00;
         prev_blk     = 2'b00;
         cfg_m        = '{wave_sel: WAVE_SINE, mod_sel: MOD_ASK, fsk_inc: '0};
         lfsr_m       = 5'b00001;
         seq[0]       = 1'b1;
         lfsr_pos     = 0;
         last_pos     = 0;
         have_prev    = 1'b0;
         hop_flag     = 1'b0;
         hop_win      = 1'b0;
      end
      else
      begin
         for (int s = 0; s < 2; s++)
         begin
            if (prev_blk[s] && changed[s])
               flag_mismatch($sformatf("stream %0d payload moved while stalled", s));
            if (vld[s] != exp_vld[s])
               flag_mismatch($sformatf("stream %0d valid is %0b, expected %0b",
                                       s, vld[s], exp_vld[s]));
         end
         if (wave_drops != exp_drops[0] || mod_drops != exp_drops[1])
            flag_mismatch($sformatf("drop counts %0d/%0d, expected %0d/%0d",
                                    wave_drops, mod_drops, exp_drops[0], exp_drops[1]));
         if (wave_valid && wave_ready)
            check_wave(wave_data);
         if (mod_valid && mod_ready)
            check_mod(mod_data);

         tick    = cyc != 0 && cyc % SAMPLE_DIV == 0;   // sample_tick high now
         exp_vld = tick ? 2'b11 : blk;                  // new load or item still held
         for (int s = 0; s < 2; s++)
            if (tick && blk[s])
               exp_drops[s]++;
         if (cfg_valid)
            cfg_m = cfg;
         hopping  = cfg_m.mod_sel == MOD_FSK && cfg_m.fsk_inc != BASE_INC;
         hop_flag = hop_flag | hopping;
         if (tick && !blk[1])
         begin
            load_k   = cyc;
            item_hop = hop_flag | hop_win;   // previous window covers pipeline lag
            hop_win  = hop_flag;
            hop_flag = hopping;
         end
         if (cyc != 0 && cyc % LFSR_DIV == 0 && lfsr_pos < 511)
         begin
            lfsr_m = {lfsr_m[3:0], lfsr_m[4] ^ lfsr_m[2]};
            lfsr_pos++;
            seq[lfsr_pos] = lfsr_m[0];
         end
         prev_blk = blk;
         cyc++;
      end
      prev_wave = wave_data;
      prev_mod  = mod_data;
   end

endmodule

// ==== tb/dds_mod_tb.sv ====
`timescale 1ns/1ps

module dds_mod_tb
   import dds_pkg::*;
();

   localparam int unsigned BASE_INC   = 32'h0123_4567;   // about one idx step per cycle
   localparam int unsigned LFSR_DIV   = 20;
   localparam int unsigned SAMPLE_DIV = 7;
   localparam int PHASES      = 8;
   localparam int PHASE_LEN   = 400;
   localparam int PERIOD_NS   = 40;
   localparam int MIN_ACCEPTS = 100;

   logic         CLK_25MHZ;
   logic         reset_from_key;
   dds_cfg_t     cfg;
   logic         cfg_valid;
   logic         wave_ready;
   logic         mod_ready;
   wave_sample_t wave_data;
   logic         wave_valid;
   mod_sample_t  mod_data;
   logic         mod_valid;
   logic [15:0]  wave_drops;
   logic [15:0]  mod_drops;
   int           mismatch_count;
   int           fault_count;
   int           accept_count;
   logic [15:0]  rng = 16'd74;

   tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(16)) tb_clock_i (.*);

   dds_mod_top #(
      .BASE_INC   (BASE_INC),
      .LFSR_DIV   (LFSR_DIV),
      .SAMPLE_DIV (SAMPLE_DIV)
   ) dds_mod_top_i (.*);

   dds_mod_checker #(
      .BASE_INC   (BASE_INC),
      .LFSR_DIV   (LFSR_DIV),
      .SAMPLE_DIV (SAMPLE_DIV)
   ) dds_mod_checker_i (.*);

   ////////////////////////////////////////////////////////////
   // random source
   ////////////////////////////////////////////////////////////
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         rng = lfsr_next(rng);
         v   = {v[30:0], rng[0]};
      end
      return v;
   endfunction

   // one configuration with readies at a random per-phase duty
   task automatic run_phase(input int p);
      dds_cfg_t    c;
      int          wave_thr;
      int          mod_thr;
      c.wave_sel = wave_sel_e'(2'(p));       // every shape twice
      c.mod_sel  = mod_sel_e'(2'(p / 2));    // ask, fsk, bpsk, lfsr in turn
      c.fsk_inc  = take_bits(32);
      if (p == 6)
         c.mod_sel = MOD_FSK;
      if (p == 6 || take_bits(2) == 0)
         c.fsk_inc = BASE_INC;          // fsk at the base rate
      wave_thr = (p == 0 || p == 4) ? 8 : 1 + int'(take_bits(3));   // 8 is always ready
      mod_thr  = (p == 0 || p == 4) ? 8 : 1 + int'(take_bits(3));
      for (int i = 0; i < PHASE_LEN; i++)
      begin
         @(posedge CLK_25MHZ);
         cfg        <= c;
         cfg_valid  <= (i == 0);
         wave_ready <= int'(take_bits(3)) < wave_thr;
         mod_ready  <= int'(take_bits(3)) < mod_thr;
      end
   endtask

   initial
   begin
      cfg        = '0;
      cfg_valid  = 1'b0;
      wave_ready = 1'b0;
      mod_ready  = 1'b0;
      @(negedge reset_from_key);
      for (int p = 0; p < PHASES; p++)
         run_phase(p);
      repeat (4) @(posedge CLK_25MHZ);
      $display("%0d mismatches, %0d other errors, %0d samples accepted",
               mismatch_count, fault_count, accept_count);
      if (accept_count < MIN_ACCEPTS)
         $display("Too few samples were accepted to judge the run");
      if (mismatch_count == 0 && fault_count == 0 && accept_count >= MIN_ACCEPTS)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // watchdog at half again the stimulus length
   initial
   begin
      #(PHASES * PHASE_LEN * PERIOD_NS * 3 / 2);
      $display("Timeout: stimulus did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+src
src/dds_pkg.sv
src/mod_control.sv
src/dds_core.sv
src/lfsr_source.sv
src/modulator.sv
src/sample_outbuf.sv
src/dds_mod_top.sv
tb/tb_clock.sv
tb/dds_mod_checker.sv
tb/dds_mod_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, pass only when the log holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module dds_mod_tb \
   -Mdir obj_dir -o dds_mod_sim > build.log 2>&1 &&
./obj_dir/dds_mod_sim > sim.log 2>&1 &&
grep -q "^Result: PASSED$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
